//--- source/mem_ctl_consts.svh
// Shared constants for the memory controller
//   Address map decode values for flash and GPIO
//   SPI command opcodes
//   GPIO register width and SPI address width
`ifndef MEM_CTL_CONSTS_SVH
`define MEM_CTL_CONSTS_SVH

// Top address byte that selects the flash region
`define FLASH_REGION 8'h80

// Upper 24 address bits of the GPIO page
// Decoded before the RAM region
`define GPIO_PAGE 24'h000100

// Serial memory opcodes, same for flash and RAM
`define CMD_READ 8'h03
`define CMD_WRITE 8'h02

// Output register width
`define GPIO_WIDTH 8

// Address bits shifted out after the command
`define SPI_ADDR_BITS 24

`endif

//--- source/mem_ctl_pkg.sv
// Shared types of the memory controller
//   Data word and device address
//   Access size (funct3 encoding)
//   Transfer length and device select
package mem_ctl_pkg;

    typedef logic [31:0] word_t;

    typedef logic [23:0] spi_addr_t;

    // Same encoding as funct3 of loads and stores
    typedef enum logic [2:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101
    } mem_size_e;

    // Number of data bits in one SPI transfer
    typedef logic [5:0] xfer_len_t;

    typedef enum logic {
        DEV_FLASH = 1'b0,
        DEV_RAM   = 1'b1
    } dev_sel_e;

endpackage

//--- source/mem_req_arbiter.sv
// Request arbiter
//   Pending slots for the fetch and the data path
//   Region decode and the GPIO output register
//   Data-first issue of SPI transfers to the sequencer
`timescale 1ns/1ns
`include "mem_ctl_consts.svh"

module mem_req_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_req,
    input  mem_ctl_pkg::word_t      instr_addr,
    input  logic                    mem_we,
    input  logic                    mem_re,
    input  mem_ctl_pkg::word_t      mem_addr,
    input  mem_ctl_pkg::word_t      mem_wdata,
    input  mem_ctl_pkg::mem_size_e  mem_size,
    input  logic                    seq_busy,
    output logic                    xfer_start,
    output logic                    xfer_is_instr,
    output logic                    xfer_write,
    output mem_ctl_pkg::dev_sel_e   xfer_dev,
    output mem_ctl_pkg::spi_addr_t  xfer_addr,
    output mem_ctl_pkg::word_t      xfer_wdata,
    output mem_ctl_pkg::mem_size_e  xfer_size,
    output logic                    gpio_done,
    output mem_ctl_pkg::word_t      gpio_rdata,
    output logic [`GPIO_WIDTH-1:0]  gpio_out
);
    import mem_ctl_pkg::*;

    logic      instr_pend;
    word_t     instr_pend_addr;
    logic      data_pend;
    logic      data_pend_write;
    word_t     data_pend_addr;
    word_t     data_pend_wdata;
    mem_size_e data_pend_size;
    logic      data_is_gpio;
    dev_sel_e  data_dev;
    logic      issue_ok;
    logic      issue_data;
    logic      issue_instr;

    assign data_is_gpio = (data_pend_addr[31:8] == `GPIO_PAGE);
    assign data_dev = (data_pend_addr[31:24] == `FLASH_REGION) ? DEV_FLASH : DEV_RAM;

    // Hold off while a start is still on its way to the sequencer
    assign issue_ok = !seq_busy && !xfer_start;
    assign issue_data = data_pend && !data_is_gpio && issue_ok;
    assign issue_instr = instr_pend && issue_ok && !(data_pend && !data_is_gpio);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_pend <= 1'b0;
            data_pend  <= 1'b0;
            xfer_start <= 1'b0;
            gpio_done  <= 1'b0;
            gpio_out   <= '0;
        end else begin
            xfer_start <= issue_data || issue_instr;
            gpio_done  <= data_pend && data_is_gpio;

            // A repeated strobe while one is pending is dropped
            if (instr_pend) begin
                if (issue_instr) begin
                    instr_pend <= 1'b0;
                end
            end else if (instr_req) begin
                instr_pend <= 1'b1;
            end

            if (data_pend) begin
                if (issue_data || data_is_gpio) begin
                    data_pend <= 1'b0;
                end
            end else if (mem_we || mem_re) begin
                data_pend <= 1'b1;
            end

            if (data_pend && data_is_gpio && data_pend_write) begin
                gpio_out <= data_pend_wdata[`GPIO_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!instr_pend && instr_req) begin
            instr_pend_addr <= instr_addr;
        end
        if (!data_pend && (mem_we || mem_re)) begin
            data_pend_write <= mem_we;
            data_pend_addr  <= mem_addr;
            data_pend_wdata <= mem_wdata;
            data_pend_size  <= mem_size;
        end

        // Write returns zero, read returns the register zero-extended
        if (data_pend && data_is_gpio) begin
            gpio_rdata <= data_pend_write ? '0 : {{(32-`GPIO_WIDTH){1'b0}}, gpio_out};
        end

        if (issue_data) begin
            xfer_is_instr <= 1'b0;
            xfer_write    <= data_pend_write;
            xfer_dev      <= data_dev;
            xfer_addr     <= data_pend_addr[`SPI_ADDR_BITS-1:0];
            xfer_wdata    <= data_pend_wdata;
            xfer_size     <= data_pend_size;
        end else if (issue_instr) begin
            // Fetches always read a full word from flash
            xfer_is_instr <= 1'b1;
            xfer_write    <= 1'b0;
            xfer_dev      <= DEV_FLASH;
            xfer_addr     <= instr_pend_addr[`SPI_ADDR_BITS-1:0];
            xfer_wdata    <= '0;
            xfer_size     <= SIZE_W;
        end
    end

endmodule

//--- source/mem_access_seq.sv
// Access sequencer
//   Command and length selection from the access size
//   Store data packing, lowest byte first on the bus
//   Chip select for flash or RAM over the whole transfer
//   Completion strobes towards the response side
`timescale 1ns/1ns
`include "mem_ctl_consts.svh"

module mem_access_seq (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    xfer_start,
    input  logic                    xfer_is_instr,
    input  logic                    xfer_write,
    input  mem_ctl_pkg::dev_sel_e   xfer_dev,
    input  mem_ctl_pkg::spi_addr_t  xfer_addr,
    input  mem_ctl_pkg::word_t      xfer_wdata,
    input  mem_ctl_pkg::mem_size_e  xfer_size,
    input  logic                    spi_done,
    input  mem_ctl_pkg::word_t      spi_rdata,
    output logic                    seq_busy,
    output logic                    spi_start,
    output logic [7:0]              spi_cmd,
    output mem_ctl_pkg::spi_addr_t  spi_addr,
    output mem_ctl_pkg::xfer_len_t  spi_len,
    output mem_ctl_pkg::word_t      spi_wdata,
    output logic                    flash_cs_n,
    output logic                    ram_cs_n,
    output logic                    fetch_done,
    output logic                    data_done,
    output mem_ctl_pkg::word_t      raw_data,
    output mem_ctl_pkg::mem_size_e  done_size
);
    import mem_ctl_pkg::*;

    logic      cur_is_instr;
    logic      cur_write;
    xfer_len_t len_sel;
    word_t     packed_wdata;

    // Data is right-aligned and shifted MSB first,
    // so the lowest address byte sits in the top used byte
    always_comb begin
        len_sel = 6'd32;
        packed_wdata = {xfer_wdata[7:0], xfer_wdata[15:8],
                        xfer_wdata[23:16], xfer_wdata[31:24]};
        if (!xfer_is_instr) begin
            case (xfer_size)
                SIZE_B, SIZE_BU: begin
                    len_sel = 6'd8;
                    packed_wdata = {24'h0, xfer_wdata[7:0]};
                end
                SIZE_H, SIZE_HU: begin
                    len_sel = 6'd16;
                    packed_wdata = {16'h0, xfer_wdata[7:0], xfer_wdata[15:8]};
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seq_busy   <= 1'b0;
            spi_start  <= 1'b0;
            flash_cs_n <= 1'b1;
            ram_cs_n   <= 1'b1;
            fetch_done <= 1'b0;
            data_done  <= 1'b0;
        end else begin
            spi_start  <= 1'b0;
            fetch_done <= 1'b0;
            data_done  <= 1'b0;
            if (xfer_start && !seq_busy) begin
                seq_busy   <= 1'b1;
                spi_start  <= 1'b1;
                flash_cs_n <= (xfer_dev != DEV_FLASH);
                ram_cs_n   <= (xfer_dev != DEV_RAM);
            end else if (seq_busy && spi_done) begin
                seq_busy   <= 1'b0;
                flash_cs_n <= 1'b1;
                ram_cs_n   <= 1'b1;
                fetch_done <= cur_is_instr;
                data_done  <= !cur_is_instr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_start && !seq_busy) begin
            spi_cmd      <= xfer_write ? `CMD_WRITE : `CMD_READ;
            spi_addr     <= xfer_addr;
            spi_len      <= len_sel;
            spi_wdata    <= packed_wdata;
            cur_is_instr <= xfer_is_instr;
            cur_write    <= xfer_write;
            done_size    <= xfer_is_instr ? SIZE_W : xfer_size;
        end
        // Stores report zero read data
        if (seq_busy && spi_done) begin
            raw_data <= cur_write ? '0 : spi_rdata;
        end
    end

endmodule

//--- source/spi_master.sv
// Single-line SPI master, mode 0
//   Shifts an 8-bit command, the device address and the data bits
//   SCLK runs at half the system clock
//   Read data comes back right-aligned
`timescale 1ns/1ns
`include "mem_ctl_consts.svh"

module spi_master (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    spi_start,
    input  logic [7:0]              spi_cmd,
    input  mem_ctl_pkg::spi_addr_t  spi_addr,
    input  mem_ctl_pkg::xfer_len_t  spi_len,
    input  mem_ctl_pkg::word_t      spi_wdata,
    input  logic                    spi_miso,
    output logic                    spi_done,
    output mem_ctl_pkg::word_t      spi_rdata,
    output logic                    spi_sclk,
    output logic                    spi_mosi,
    output logic                    active
);
    import mem_ctl_pkg::*;

    localparam logic [6:0] HDR_BITS = 7'(8 + `SPI_ADDR_BITS);
    localparam int SHIFT_BITS = 8 + `SPI_ADDR_BITS + 32;

    logic [SHIFT_BITS-1:0] tx_shift;
    word_t                 rx_shift;
    word_t                 wdata_aligned;
    xfer_len_t             data_len;
    logic [6:0]            bits_left;
    logic                  in_data;
    logic                  last_bit;

    // Move the data bits up against the address
    assign wdata_aligned = spi_wdata << (6'd32 - spi_len);

    // Counter includes the bit on the wire
    assign in_data = (bits_left <= {1'b0, data_len});
    assign last_bit = (bits_left == 7'd1);
    assign spi_mosi = active && tx_shift[SHIFT_BITS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            spi_sclk  <= 1'b0;
            spi_done  <= 1'b0;
            bits_left <= '0;
        end else begin
            spi_done <= 1'b0;
            if (spi_start && !active) begin
                active    <= 1'b1;
                spi_sclk  <= 1'b0;
                bits_left <= HDR_BITS + {1'b0, spi_len};
            end else if (active) begin
                spi_sclk <= !spi_sclk;
                // Falling edge ends the current bit
                if (spi_sclk) begin
                    bits_left <= bits_left - 7'd1;
                    if (last_bit) begin
                        active   <= 1'b0;
                        spi_done <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (spi_start && !active) begin
            tx_shift <= {spi_cmd, spi_addr, wdata_aligned};
            rx_shift <= '0;
            data_len <= spi_len;
        end else if (active) begin
            // Sample with the rising SCLK edge
            if (!spi_sclk && in_data) begin
                rx_shift <= {rx_shift[30:0], spi_miso};
            end
            if (spi_sclk) begin
                tx_shift <= {tx_shift[SHIFT_BITS-2:0], 1'b0};
            end
        end
        if (active && spi_sclk && last_bit) begin
            spi_rdata <= rx_shift;
        end
    end

endmodule

//--- source/mem_resp_unpack.sv
// Response unpacking
//   Byte reorder of received data into little-endian words
//   Sign and zero extension of byte and halfword loads
//   Registered fetch and data ready strobes
`timescale 1ns/1ns

module mem_resp_unpack (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fetch_done,
    input  logic                    data_done,
    input  mem_ctl_pkg::word_t      raw_data,
    input  mem_ctl_pkg::mem_size_e  done_size,
    input  logic                    gpio_done,
    input  mem_ctl_pkg::word_t      gpio_rdata,
    output logic                    instr_valid,
    output mem_ctl_pkg::word_t      instr_data,
    output logic                    mem_ready,
    output mem_ctl_pkg::word_t      mem_rdata
);
    import mem_ctl_pkg::*;

    word_t       swapped;
    logic [15:0] half;
    word_t       load_val;

    // First received byte is the lowest address
    assign swapped = {raw_data[7:0], raw_data[15:8], raw_data[23:16], raw_data[31:24]};
    assign half = {raw_data[7:0], raw_data[15:8]};

    always_comb begin
        case (done_size)
            SIZE_B:  load_val = {{24{raw_data[7]}}, raw_data[7:0]};
            SIZE_BU: load_val = {24'h0, raw_data[7:0]};
            SIZE_H:  load_val = {{16{half[15]}}, half};
            SIZE_HU: load_val = {16'h0, half};
            default: load_val = swapped;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_valid <= 1'b0;
            mem_ready   <= 1'b0;
        end else begin
            instr_valid <= fetch_done;
            mem_ready   <= data_done || gpio_done;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr_data <= swapped;
        end
        if (data_done) begin
            mem_rdata <= load_val;
        end else if (gpio_done) begin
            mem_rdata <= gpio_rdata;
        end
    end

endmodule

//--- source/mem_ctl.sv
// Memory controller top level
//   Request arbiter, access sequencer, SPI master
//   and response unpacking, joined by name
`timescale 1ns/1ns
`include "mem_ctl_consts.svh"

module mem_ctl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_req,
    input  mem_ctl_pkg::word_t      instr_addr,
    input  logic                    mem_we,
    input  logic                    mem_re,
    input  mem_ctl_pkg::word_t      mem_addr,
    input  mem_ctl_pkg::word_t      mem_wdata,
    input  mem_ctl_pkg::mem_size_e  mem_size,
    input  logic                    spi_miso,
    output logic                    instr_valid,
    output mem_ctl_pkg::word_t      instr_data,
    output logic                    mem_ready,
    output mem_ctl_pkg::word_t      mem_rdata,
    output logic [`GPIO_WIDTH-1:0]  gpio_out,
    output logic                    flash_cs_n,
    output logic                    ram_cs_n,
    output logic                    spi_sclk,
    output logic                    spi_mosi
);

    // Arbiter to sequencer
    logic                   seq_busy;
    logic                   xfer_start;
    logic                   xfer_is_instr;
    logic                   xfer_write;
    mem_ctl_pkg::dev_sel_e  xfer_dev;
    mem_ctl_pkg::spi_addr_t xfer_addr;
    mem_ctl_pkg::word_t     xfer_wdata;
    mem_ctl_pkg::mem_size_e xfer_size;

    // GPIO response path
    logic                   gpio_done;
    mem_ctl_pkg::word_t     gpio_rdata;

    // Sequencer to SPI master
    logic                   spi_start;
    logic [7:0]             spi_cmd;
    mem_ctl_pkg::spi_addr_t spi_addr;
    mem_ctl_pkg::xfer_len_t spi_len;
    mem_ctl_pkg::word_t     spi_wdata;
    logic                   spi_done;
    mem_ctl_pkg::word_t     spi_rdata;

    // Sequencer to unpack
    logic                   fetch_done;
    logic                   data_done;
    mem_ctl_pkg::word_t     raw_data;
    mem_ctl_pkg::mem_size_e done_size;

    mem_req_arbiter i_mem_req_arbiter (.*);

    mem_access_seq i_mem_access_seq (.*);

    // Busy state is tracked by the sequencer
    spi_master i_spi_master (
        .active (),
        .*
    );

    mem_resp_unpack i_mem_resp_unpack (.*);

endmodule

//--- test/clk_rst_gen.sv
// Clock and reset source for the testbench
//   Free-running clock, 10 ns period
//   Active-low reset held for two clock cycles
`timescale 1ns/1ns

module clk_rst_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release shortly after an edge, away from the DUT sampling point
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- test/spi_mem_model.sv
// Behavioral serial memory for the testbench
//   Read (0x03) and write (0x02) commands with a 24-bit address
//   Mode 0 bus, samples MOSI on rising SCLK, updates MISO on falling SCLK
//   Consecutive data bytes go to consecutive addresses
`timescale 1ns/1ns

module spi_mem_model #(
    parameter int ADDR_BITS = 12,
    parameter bit WRITABLE  = 1'b1
) (
    input  logic cs_n,
    input  logic sclk,
    input  logic mosi,
    output logic miso
);

    logic [7:0]  mem [0:(1 << ADDR_BITS) - 1];
    logic [31:0] hdr;
    logic [7:0]  wr_byte;
    int          bit_cnt;

    // Address of the data byte that holds bit n of the transfer
    function automatic logic [ADDR_BITS-1:0] byte_addr(input int n);
        byte_addr = hdr[ADDR_BITS-1:0] + ADDR_BITS'((n - 32) / 8);
    endfunction

    initial miso = 1'b0;

    // New transfer
    always @(negedge cs_n) begin
        bit_cnt = 0;
        hdr = '0;
    end

    always @(posedge sclk) begin
        if (!cs_n) begin
            if (bit_cnt < 32) begin
                hdr = {hdr[30:0], mosi};
            end else begin
                wr_byte = {wr_byte[6:0], mosi};
                if (WRITABLE && hdr[31:24] == 8'h02 && (bit_cnt - 32) % 8 == 7) begin
                    mem[byte_addr(bit_cnt)] = wr_byte;
                end
            end
            bit_cnt = bit_cnt + 1;
        end
    end

    // First data bit goes out right after the last address bit
    always @(negedge sclk) begin
        if (!cs_n && bit_cnt >= 32 && hdr[31:24] == 8'h03) begin
            miso <= mem[byte_addr(bit_cnt)][7 - (bit_cnt - 32) % 8];
        end
    end

endmodule

//--- test/tb_mem_ctl.sv
// Testbench for the memory controller
//   Flash and RAM models on the shared SPI bus
//   Shadow memories and reference functions for expected results
//   Response checker, per-test report and cycle limit
`timescale 1ns/1ns
`include "mem_ctl_consts.svh"

module tb_mem_ctl;
    import mem_ctl_pkg::*;

    // Fetch 8, store/load 8, byte/half 9, GPIO 4, parallel 2, flash loads 4
    localparam int    NUM_XFERS  = 35;
    localparam int    MAX_CYCLES = 4 * NUM_XFERS * 130;
    localparam word_t RAM_BASE   = 32'h0000_0400;
    localparam word_t GPIO_ADDR  = {`GPIO_PAGE, 8'h00};
    localparam word_t FLASH_BASE = {`FLASH_REGION, 24'h0};

    logic                   clk;
    logic                   rst_n;
    logic                   instr_req;
    word_t                  instr_addr;
    logic                   mem_we;
    logic                   mem_re;
    word_t                  mem_addr;
    word_t                  mem_wdata;
    mem_size_e              mem_size;
    logic                   spi_miso;
    logic                   instr_valid;
    word_t                  instr_data;
    logic                   mem_ready;
    word_t                  mem_rdata;
    logic [`GPIO_WIDTH-1:0] gpio_out;
    logic                   flash_cs_n;
    logic                   ram_cs_n;
    logic                   spi_sclk;
    logic                   spi_mosi;
    logic                   flash_miso;
    logic                   ram_miso;

    logic [7:0]             flash_shadow [0:4095];
    logic [7:0]             ram_shadow [0:4095];
    logic [`GPIO_WIDTH-1:0] gpio_shadow;

    // One outstanding request per path
    logic  instr_wait;
    word_t instr_exp;
    int    instr_done_cycle;
    logic  data_wait;
    word_t data_exp;
    logic  data_timed;
    int    data_strobe_cycle;
    int    data_done_cycle;

    int    cycle = 0;
    int    errors = 0;
    int    test_errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    string test_name;
    word_t addr_r;
    word_t data_r;

    clk_rst_gen i_clk_rst_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_ctl i_mem_ctl (.*);

    spi_mem_model #(.WRITABLE(1'b0)) i_flash (
        .cs_n (flash_cs_n),
        .sclk (spi_sclk),
        .mosi (spi_mosi),
        .miso (flash_miso)
    );

    spi_mem_model i_ram (
        .cs_n (ram_cs_n),
        .sclk (spi_sclk),
        .mosi (spi_mosi),
        .miso (ram_miso)
    );

    assign spi_miso = !flash_cs_n ? flash_miso : ram_miso;

    // Little-endian word from a shadow array
    function automatic word_t shadow_word(input logic from_flash, input logic [11:0] a);
        word_t w;
        w = '0;
        for (int i = 3; i >= 0; i--) begin
            w = {w[23:0], from_flash ? flash_shadow[a + 12'(i)] : ram_shadow[a + 12'(i)]};
        end
        return w;
    endfunction

    function automatic word_t exp_fetch(input word_t addr);
        return shadow_word(1'b1, addr[11:0]);
    endfunction

    // Signed loads extend bit 7 or 15, unsigned ones fill with zeros
    function automatic word_t exp_load(input word_t addr, input mem_size_e size);
        word_t w;
        w = shadow_word(addr[31:24] == `FLASH_REGION, addr[11:0]);
        case (size)
            SIZE_B:  return {{24{w[7]}}, w[7:0]};
            SIZE_BU: return {24'h0, w[7:0]};
            SIZE_H:  return {{16{w[15]}}, w[15:0]};
            SIZE_HU: return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic shadow_store(input word_t addr, input word_t wdata, input mem_size_e size);
        int n;
        n = (size == SIZE_W) ? 4 : (size == SIZE_H || size == SIZE_HU) ? 2 : 1;
        for (int i = 0; i < n; i++) begin
            ram_shadow[addr[11:0] + 12'(i)] = wdata[8*i +: 8];
        end
    endtask

    function automatic word_t rand_offset();
        return {20'h0, 12'($urandom) & 12'hFFC};
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_gpio(input logic [`GPIO_WIDTH-1:0] got,
                              input logic [`GPIO_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] gpio_out: got 0x%02h, expected 0x%02h", got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_fail(input string what);
        $display("%s (cycle %0d)", what, cycle);
        errors++;
        test_errors++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("Test %0d %-16s %s", tests_run, test_name, (test_errors == 0) ? "ok" : "failed");
    endtask

    // Caller sits 1 ns after a rising edge
    task automatic issue_fetch(input word_t addr);
        instr_req = 1'b1;
        instr_addr = addr;
        instr_exp = exp_fetch(addr);
        instr_wait = 1'b1;
    endtask

    task automatic issue_data(input logic write, input word_t addr, input word_t wdata,
                              input mem_size_e size);
        mem_we = write;
        mem_re = !write;
        mem_addr = addr;
        mem_wdata = wdata;
        mem_size = size;
        data_timed = (addr[31:8] == `GPIO_PAGE);
        if (write) begin
            data_exp = '0;
            if (data_timed) begin
                gpio_shadow = wdata[`GPIO_WIDTH-1:0];
            end else begin
                shadow_store(addr, wdata, size);
            end
        end else if (data_timed) begin
            data_exp = {{(32-`GPIO_WIDTH){1'b0}}, gpio_shadow};
        end else begin
            data_exp = exp_load(addr, size);
        end
        // The next rising edge samples the strobe
        data_strobe_cycle = cycle + 1;
        data_wait = 1'b1;
    endtask

    task automatic end_strobe();
        @(posedge clk);
        #1;
        instr_req = 1'b0;
        mem_we = 1'b0;
        mem_re = 1'b0;
    endtask

    task automatic wait_idle();
        while (instr_wait || data_wait) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic do_fetch(input word_t addr);
        @(posedge clk);
        #1;
        issue_fetch(addr);
        end_strobe();
        wait_idle();
    endtask

    task automatic do_data(input logic write, input word_t addr, input word_t wdata,
                           input mem_size_e size);
        @(posedge clk);
        #1;
        issue_data(write, addr, wdata, size);
        end_strobe();
        wait_idle();
    endtask

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout: no finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Compare at each ready strobe, half a cycle after the DUT updates
    always @(negedge clk) begin
        // Flash and RAM share MISO, so one select at a time
        if (rst_n && !flash_cs_n && !ram_cs_n) begin
            report_fail("flash_cs_n and ram_cs_n are both low");
        end
        if (rst_n && instr_valid) begin
            if (!instr_wait) begin
                report_fail("instr_valid arrived with no fetch pending");
            end else begin
                check_word("instr_data", instr_data, instr_exp);
                instr_done_cycle = cycle;
                instr_wait = 1'b0;
            end
        end
        if (rst_n && mem_ready) begin
            if (!data_wait) begin
                report_fail("mem_ready arrived with no data access pending");
            end else begin
                check_word("mem_rdata", mem_rdata, data_exp);
                if (data_timed && cycle - data_strobe_cycle != 2) begin
                    report_fail($sformatf("GPIO mem_ready came %0d cycles after the strobe",
                                          cycle - data_strobe_cycle));
                end
                data_done_cycle = cycle;
                data_wait = 1'b0;
            end
        end
    end

    initial begin
        void'($urandom(8398));
        instr_req = 1'b0;
        instr_addr = '0;
        mem_we = 1'b0;
        mem_re = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        mem_size = SIZE_W;
        instr_wait = 1'b0;
        data_wait = 1'b0;
        data_timed = 1'b0;
        gpio_shadow = '0;
        for (int i = 0; i < 4096; i++) begin
            flash_shadow[i] = 8'($urandom);
            ram_shadow[i] = 8'($urandom);
            i_flash.mem[i] = flash_shadow[i];
            i_ram.mem[i] = ram_shadow[i];
        end
        wait (rst_n);
        @(posedge clk);
        #1;

        start_test("fetch");
        for (int i = 0; i < 8; i++) begin
            do_fetch(rand_offset());
        end
        end_test();

        start_test("store/load word");
        for (int i = 0; i < 4; i++) begin
            addr_r = RAM_BASE + (rand_offset() & 32'h0000_03FC);
            data_r = $urandom;
            do_data(1'b1, addr_r, data_r, SIZE_W);
            do_data(1'b0, addr_r, '0, SIZE_W);
        end
        end_test();

        // Final word load shows the untouched neighbour bytes
        start_test("byte/half");
        addr_r = RAM_BASE + 32'h800;
        do_data(1'b1, addr_r, 32'h1122_3344, SIZE_W);
        do_data(1'b1, addr_r + 1, 32'hABCD_EFF5, SIZE_B);
        do_data(1'b0, addr_r + 1, '0, SIZE_B);
        do_data(1'b0, addr_r + 1, '0, SIZE_BU);
        do_data(1'b1, addr_r + 2, 32'h5555_9A80, SIZE_H);
        do_data(1'b0, addr_r + 2, '0, SIZE_H);
        do_data(1'b0, addr_r + 2, '0, SIZE_HU);
        do_data(1'b0, addr_r, '0, SIZE_B);
        do_data(1'b0, addr_r, '0, SIZE_W);
        end_test();

        start_test("gpio");
        check_gpio(gpio_out, gpio_shadow);
        do_data(1'b1, GPIO_ADDR, 32'h1234_56A5, SIZE_W);
        check_gpio(gpio_out, gpio_shadow);
        do_data(1'b0, GPIO_ADDR, '0, SIZE_W);
        do_data(1'b1, GPIO_ADDR + 4, 32'h0000_003C, SIZE_B);
        check_gpio(gpio_out, gpio_shadow);
        do_data(1'b0, GPIO_ADDR, '0, SIZE_BU);
        end_test();

        // Both strobes in one cycle, data has priority
        start_test("fetch+data");
        @(posedge clk);
        #1;
        issue_fetch(rand_offset());
        issue_data(1'b0, RAM_BASE + 32'h100, '0, SIZE_W);
        end_strobe();
        wait_idle();
        if (data_done_cycle >= instr_done_cycle) begin
            report_fail("instr_valid did not come after mem_ready");
        end
        end_test();

        start_test("flash loads");
        do_data(1'b0, FLASH_BASE | rand_offset(), '0, SIZE_W);
        do_data(1'b0, (FLASH_BASE | rand_offset()) + 1, '0, SIZE_B);
        do_data(1'b0, (FLASH_BASE | rand_offset()) + 2, '0, SIZE_H);
        do_data(1'b0, FLASH_BASE | rand_offset(), '0, SIZE_HU);
        end_test();

        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- mem_ctl.f
+incdir+source
source/mem_ctl_pkg.sv
source/mem_req_arbiter.sv
source/mem_access_seq.sv
source/spi_master.sv
source/mem_resp_unpack.sv
source/mem_ctl.sv
test/clk_rst_gen.sv
test/spi_mem_model.sv
test/tb_mem_ctl.sv

//--- Bender.yml
package:
  name: mem_ctl

sources:
  - include_dirs:
      - source
    files:
      - source/mem_ctl_pkg.sv
      - source/mem_req_arbiter.sv
      - source/mem_access_seq.sv
      - source/spi_master.sv
      - source/mem_resp_unpack.sv
      - source/mem_ctl.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/clk_rst_gen.sv
      - test/spi_mem_model.sv
      - test/tb_mem_ctl.sv
